// File: verif/program_trace.txt
// counts (program words, retirements, final registers), then program words,
// then retire pairs "rd value" in program order, then final pairs "reg value", all hex
00000024 00000018 00000006
// program, two words per line
ff000093 00500113 // addi x1,x0,-16 ; addi x2,x0,5
002081b3 40110233 // add x3,x1,x2 ; sub x4,x2,x1
002112b3 0020a333 // sll x5,x2,x2 ; slt x6,x1,x2
0020b3b3 0020c433 // sltu x7,x1,x2 ; xor x8,x1,x2
0020d4b3 4020d533 // srl x9,x1,x2 ; sra x10,x1,x2
0022e5b3 0040f633 // or x11,x5,x2 ; and x12,x1,x4
fff0a693 fff13713 // slti x13,x1,-1 ; sltiu x14,x2,-1
fff14793 7f016813 // xori x15,x2,-1 ; ori x16,x2,0x7f0
0ff0f893 01c11913 // andi x17,x1,0xff ; slli x18,x2,28
0040d993 4020da13 // srli x19,x1,4 ; srai x20,x1,2
abcdeab7 00110013 // lui x21,0xabcde ; addi x0,x2,1
00210463 00100b13 // beq x2,x2,+8 taken ; addi x22,x0,1 squashed
00209463 00200b13 // bne x1,x2,+8 taken ; addi x22,x0,2 squashed
0020c463 00300b13 // blt x1,x2,+8 taken ; addi x22,x0,3 squashed
0020f463 00400b13 // bgeu x1,x2,+8 taken ; addi x22,x0,4 squashed
00208463 00500b13 // beq x1,x2,+8 not taken ; addi x22,x0,5
00800bef 00600b13 // jal x23,+8 ; addi x22,x0,6 squashed
001b8c13 0000006f // addi x24,x23,1 ; jal x0,0
// expected retirements, two pairs per line
01 fffffff0 02 00000005
03 fffffff5 04 00000015
05 000000a0 06 00000001
07 00000000 08 fffffff5
09 07ffffff 0a ffffffff
0b 000000a5 0c 00000010
0d 00000001 0e 00000001
0f fffffffa 10 000007f5
11 000000f0 12 50000000
13 0fffffff 14 fffffffc
15 abcde000 16 00000005
17 00000084 18 00000085
// expected final registers
00 00000000 01 fffffff0
15 abcde000 16 00000005
17 00000084 18 00000085

// File: sources.f
+incdir+design
design/rv_pkg.sv
design/imm_gen.sv
design/alu.sv
design/reg_file.sv
design/core_pipeline.sv
design/rv_top.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sources.f --top-module tb_top -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

// File: verif/tb_top.sv
`include "rv_settings.svh"

module tb_top
	import rv_pkg::*;
();
	localparam int TRACE_DEPTH = 128;
	localparam int CLK_HALF = 4;
	localparam int RESET_CYCLES = 5;

	logic                clk;
	logic                rstn;
	logic [`IMEM_AW-1:0] imem_addr;
	word_t               imem_data;
	logic                wb_valid;
	reg_addr_t           wb_rd;
	word_t               wb_data;
	reg_addr_t           dbg_addr;
	word_t               dbg_data;

	word_t trace [0:TRACE_DEPTH-1]; // counts, program, retire pairs, final pairs
	int    n_prog;

	rv_top DUT (
		.clk         (clk),
		.rstn        (rstn),
		.imem_addr_o (imem_addr),
		.imem_data_i (imem_data),
		.wb_valid_o  (wb_valid),
		.wb_rd_o     (wb_rd),
		.wb_data_o   (wb_data),
		.dbg_addr_i  (dbg_addr),
		.dbg_data_o  (dbg_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// words past the program hold a jal x0,0 self-loop
	function automatic word_t rom_word(input logic [`IMEM_AW-1:0] addr);
		if (int'(addr) < n_prog)
			return trace[3 + int'(addr)];
		return 32'h0000_006f;
	endfunction

	// program ROM
	initial
	begin
		imem_data = '0;
		forever
		begin
			@(negedge clk);
			imem_data = rom_word(imem_addr);
		end
	end

	initial
	begin
		int        n_ret;
		int        n_final;
		int        ret_base;
		int        final_base;
		int        ret_idx;
		int        cycle_cnt;
		int        cycle_limit;
		reg_addr_t exp_rd;
		word_t     exp_val;

		rstn = 1'b0;
		dbg_addr = '0;
		n_prog = 0;
		$readmemh("verif/program_trace.txt", trace);
		n_prog = int'(trace[0]);
		n_ret = int'(trace[1]);
		n_final = int'(trace[2]);
		assert (n_prog > 0 && n_ret > 0 && 3 + n_prog + 2 * (n_ret + n_final) <= TRACE_DEPTH)
		else
		begin
			$display("trace file verif/program_trace.txt is missing, empty or too long");
			$display("ERRORS FOUND");
			$fatal(1);
		end
		ret_base = 3 + n_prog;
		final_base = ret_base + 2 * n_ret;
		cycle_limit = 20 + 4 * (n_prog + n_ret);
		cycle_cnt = 0;
		ret_idx = 0;

		repeat (RESET_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		@(negedge clk);
		rstn = 1'b1;

		while (ret_idx < n_ret)
		begin
			@(posedge clk);
			cycle_cnt++;
			assert (cycle_cnt < cycle_limit)
			else
			begin
				$display("timeout: retirements stopped after %0d of %0d", ret_idx, n_ret);
				$display("ERRORS FOUND");
				$fatal(1);
			end
			if (wb_valid)
			begin
				exp_rd = reg_addr_t'(trace[ret_base + 2 * ret_idx]);
				exp_val = trace[ret_base + 2 * ret_idx + 1];
				assert (wb_rd == exp_rd && wb_data == exp_val)
				else
				begin
					$display("FAIL t=%0t retire %0d: x%0d = %h, expected x%0d = %h",
						$time, ret_idx, wb_rd, wb_data, exp_rd, exp_val);
					$display("ERRORS FOUND");
					$fatal(1);
				end
				ret_idx++;
			end
		end

		repeat (4) // core should sit in the self-loop now
		begin
			@(posedge clk);
			assert (!wb_valid)
			else
			begin
				$display("FAIL t=%0t unexpected retirement x%0d = %h", $time, wb_rd, wb_data);
				$display("ERRORS FOUND");
				$fatal(1);
			end
		end

		for (int k = 0; k < n_final; k++)
		begin
			@(negedge clk);
			dbg_addr = reg_addr_t'(trace[final_base + 2 * k]);
			exp_val = trace[final_base + 2 * k + 1];
			@(posedge clk);
			assert (dbg_data == exp_val)
			else
			begin
				$display("FAIL t=%0t final x%0d = %h, expected %h",
					$time, dbg_addr, dbg_data, exp_val);
				$display("ERRORS FOUND");
				$fatal(1);
			end
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: design/rv_top.sv
`include "rv_settings.svh"

module rv_top
	import rv_pkg::*;
(
	input  logic                clk,
	input  logic                rstn,
	output logic [`IMEM_AW-1:0] imem_addr_o,
	input  word_t               imem_data_i,
	output logic                wb_valid_o,
	output reg_addr_t           wb_rd_o,
	output word_t               wb_data_o,
	input  reg_addr_t           dbg_addr_i,
	output word_t               dbg_data_o
);
	wb_reg_t wb;

	// retire strobe
	assign wb_valid_o = wb.we;
	assign wb_rd_o = wb.rd;
	assign wb_data_o = wb.data;

	core_pipeline u_core (
		.clk         (clk),
		.rstn        (rstn),
		.imem_addr_o (imem_addr_o),
		.imem_data_i (imem_data_i),
		.wb_o        (wb),
		.dbg_addr_i  (dbg_addr_i),
		.dbg_data_o  (dbg_data_o)
	);

endmodule

// File: design/core_pipeline.sv
`include "rv_settings.svh"

module core_pipeline
	import rv_pkg::*;
(
	input  logic                clk,
	input  logic                rstn,
	output logic [`IMEM_AW-1:0] imem_addr_o,
	input  word_t               imem_data_i,
	output wb_reg_t             wb_o,
	input  reg_addr_t           dbg_addr_i,
	output word_t               dbg_data_o
);
	word_t      pc;
	fetch_reg_t fd_q;
	wb_reg_t    wb_q;
	wb_reg_t    wb_d;

	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	word_t      imm;
	word_t      rs1_rf;
	word_t      rs2_rf;
	word_t      rs1_val;
	word_t      rs2_val;
	word_t      op_a;
	word_t      op_b;
	word_t      alu_res;
	word_t      target;
	alu_op_e    alu_op;
	logic       alt_op;
	logic       rd_we;
	logic       is_branch;
	logic       is_jal;
	logic       taken;

	// shared by R-type and I-type ALU ops
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			3'b111: op = ALU_AND;
		endcase
		return op;
	endfunction

	function automatic word_t fwd(input reg_addr_t rs, input word_t rf_val, input wb_reg_t wb);
		if (wb.we && wb.rd != '0 && wb.rd == rs)
			return wb.data;
		return rf_val;
	endfunction

	assign imem_addr_o = pc[`IMEM_AW+1:2]; // word address
	assign wb_o = wb_q;

	assign opcode = fd_q.instr[6:0];
	assign rd = fd_q.instr[11:7];
	assign funct3 = fd_q.instr[14:12];
	assign rs1 = fd_q.instr[19:15];
	assign rs2 = fd_q.instr[24:20];
	// addi has no sub form, bit 30 belongs to its immediate
	assign alt_op = fd_q.instr[30] && (opcode == OPC_OP || funct3 == 3'b101);

	assign rs1_val = fwd(rs1, rs1_rf, wb_q);
	assign rs2_val = fwd(rs2, rs2_rf, wb_q);
	assign target = fd_q.pc + imm;

	always_comb
	begin
		alu_op = ALU_ADD;
		op_a = rs1_val;
		op_b = rs2_val;
		rd_we = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		case (opcode)
			OPC_OP:
			begin
				alu_op = arith_op(funct3, alt_op);
				rd_we = 1'b1;
			end
			OPC_OP_IMM:
			begin
				alu_op = arith_op(funct3, alt_op);
				op_b = imm;
				rd_we = 1'b1;
			end
			OPC_LUI:
			begin
				op_a = '0;
				op_b = imm;
				rd_we = 1'b1;
			end
			OPC_BRANCH:
			begin
				is_branch = 1'b1;
				case (funct3)
					3'b000: alu_op = ALU_EQ;
					3'b001: alu_op = ALU_NE;
					3'b100: alu_op = ALU_SLT;
					3'b101: alu_op = ALU_GE;
					3'b110: alu_op = ALU_SLTU;
					3'b111: alu_op = ALU_GEU;
					default: is_branch = 1'b0;
				endcase
			end
			OPC_JAL:
			begin
				is_jal = 1'b1;
				op_a = fd_q.pc; // link value pc+4
				op_b = word_t'(4);
				rd_we = 1'b1;
			end
			default: ;
		endcase
	end

	assign taken = fd_q.valid && ((is_branch && alu_res[0]) || is_jal);

	always_comb
	begin
		wb_d.we = fd_q.valid && rd_we && (rd != '0);
		wb_d.rd = rd;
		wb_d.data = alu_res;
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			pc <= `RESET_PC;
			fd_q <= '0;
			wb_q <= '0;
		end
		else
		begin
			pc <= taken ? target : pc + word_t'(4);
			fd_q.valid <= !taken; // squash the wrong-path slot
			fd_q.instr <= imem_data_i;
			fd_q.pc <= pc;
			wb_q <= wb_d;
		end
	end

	imm_gen u_imm_gen (
		.instr_i (fd_q.instr),
		.imm_o   (imm)
	);

	alu u_alu (
		.op_i     (alu_op),
		.a_i      (op_a),
		.b_i      (op_b),
		.result_o (alu_res)
	);

	reg_file u_reg_file (
		.clk        (clk),
		.rstn       (rstn),
		.rs1_i      (rs1),
		.rs2_i      (rs2),
		.rs1_data_o (rs1_rf),
		.rs2_data_o (rs2_rf),
		.wb_i       (wb_q),
		.dbg_addr_i (dbg_addr_i),
		.dbg_data_o (dbg_data_o)
	);

endmodule

// File: design/reg_file.sv
`include "rv_settings.svh"

module reg_file
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	input  reg_addr_t rs1_i,
	input  reg_addr_t rs2_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o,
	input  wb_reg_t   wb_i,
	input  reg_addr_t dbg_addr_i,
	output word_t     dbg_data_o
);
	word_t regs [1:`REG_COUNT-1];

	// x0 reads zero, same-cycle write is passed through
	function automatic word_t read_port(input reg_addr_t a, input wb_reg_t wb);
		if (a == '0)
			return '0;
		if (wb.we && wb.rd == a)
			return wb.data;
		return regs[a];
	endfunction

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			for (int i = 1; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wb_i.we && wb_i.rd != '0)
			regs[wb_i.rd] <= wb_i.data;
	end

	always_comb
	begin
		rs1_data_o = read_port(rs1_i, wb_i);
		rs2_data_o = read_port(rs2_i, wb_i);
		dbg_data_o = read_port(dbg_addr_i, wb_i);
	end

endmodule

// File: design/alu.sv
`include "rv_settings.svh"

module alu
	import rv_pkg::*;
(
	input  alu_op_e op_i,
	input  word_t   a_i,
	input  word_t   b_i,
	output word_t   result_o
);
	localparam int SHW = $clog2(`XLEN);

	logic [SHW-1:0] shamt;

	assign shamt = b_i[SHW-1:0];

	always_comb
	begin
		result_o = '0;
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_SLL: result_o = a_i << shamt;
			ALU_SRL: result_o = a_i >> shamt;
			ALU_SRA: result_o = word_t'($signed(a_i) >>> shamt);
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_OR: result_o = a_i | b_i;
			ALU_AND: result_o = a_i & b_i;
			// compares land in bit 0
			ALU_SLT: result_o[0] = $signed(a_i) < $signed(b_i);
			ALU_SLTU: result_o[0] = a_i < b_i;
			ALU_EQ: result_o[0] = a_i == b_i;
			ALU_NE: result_o[0] = a_i != b_i;
			ALU_GE: result_o[0] = $signed(a_i) >= $signed(b_i);
			ALU_GEU: result_o[0] = a_i >= b_i;
			default: result_o = '0;
		endcase
	end

endmodule

// File: design/imm_gen.sv
`include "rv_settings.svh"

module imm_gen
	import rv_pkg::*;
(
	input  word_t instr_i,
	output word_t imm_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];

	always_comb
	begin
		case (opcode)
			OPC_OP_IMM:
			begin
				if (funct3 == 3'b001 || funct3 == 3'b101)
					imm_o = {{(`XLEN-12){1'b0}}, 1'b0, instr_i[30], 5'b0, instr_i[24:20]}; // shamt
				else
					imm_o = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
			end
			OPC_LUI: imm_o = {instr_i[31:12], 12'b0};
			OPC_BRANCH: imm_o = {{(`XLEN-12){instr_i[31]}}, instr_i[7],
				instr_i[30:25], instr_i[11:8], 1'b0};
			OPC_JAL: imm_o = {{(`XLEN-20){instr_i[31]}}, instr_i[19:12],
				instr_i[20], instr_i[30:21], 1'b0};
			default: imm_o = '0;
		endcase
	end

endmodule

// File: design/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_EQ,
		ALU_NE,
		ALU_GE,
		ALU_GEU
	} alu_op_e;

	// major opcodes handled by the core
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc; // byte address
	} fetch_reg_t;

	typedef struct packed {
		logic      we;
		reg_addr_t rd;
		word_t     data;
	} wb_reg_t;

endpackage

// File: design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath width
`define XLEN 32

`define REG_COUNT 32

// first fetch after reset
`define RESET_PC 32'h0000_0000

`define IMEM_AW 8

`endif
